//--- verif/lock_stimulus.txt
# onehot(hex) hold(cycles) flags(hex: 1 random extra hold, 2 buzzer high on cycle 2, 4 buzzer low)
# then expected display(hex) digit_count tries, all checked at the end of the hold
0000 4 0 FFF 0 0
0040 2 2 FF2 1 0
0000 1 1 FF2 1 0
0800 2 2 F24 2 0
0000 1 1 F24 2 0
0200 2 2 246 3 0
0000 1 1 246 3 0
4000 2 2 246 3 0
0000 30 5 246 3 0
0001 2 2 BCC 3 0
0000 1 1 BCC 3 0
1000 2 0 FFF 0 0
0000 1 1 FFF 0 0
0080 2 2 FF1 1 0
0000 1 1 FF1 1 0
1000 2 0 FFF 0 0
0000 1 1 FFF 0 0
# wrong code, then reset_all
0080 2 2 FF1 1 0
0000 1 1 FF1 1 0
0040 2 2 F12 2 0
0000 1 1 F12 2 0
0020 2 2 123 3 0
0000 1 1 123 3 0
0001 2 2 FFF 0 1
0000 40 5 FFF 0 1
0100 2 0 FFF 0 0
0000 1 1 FFF 0 0
# three wrong codes start the lockout
0080 2 2 FF1 1 0
0000 1 1 FF1 1 0
0040 2 2 F12 2 0
0000 1 1 F12 2 0
0020 2 2 123 3 0
0000 1 1 123 3 0
0001 2 2 FFF 0 1
0000 1 1 FFF 0 1
0080 2 2 FF1 1 1
0000 1 1 FF1 1 1
0040 2 2 F12 2 1
0000 1 1 F12 2 1
0020 2 2 123 3 1
0000 1 1 123 3 1
0001 2 2 FFF 0 2
0000 1 1 FFF 0 2
0080 2 2 FF1 1 2
0000 1 1 FF1 1 2
0040 2 2 F12 2 2
0000 1 1 F12 2 2
0020 2 2 123 3 2
0000 1 1 123 3 2
0001 2 2 F00 0 0
# lockout holds have fixed lengths so the seconds are known
0000 50 0 F02 0 0
0040 2 0 F02 0 0
0000 200 0 F12 0 0
0001 2 0 F12 0 0
0000 160 5 FFF 0 0
0040 2 2 FF2 1 0
0000 1 1 FF2 1 0

//--- sim.f
rtl/lock_pkg.sv
rtl/tone_pkg.sv
rtl/key_decoder.sv
rtl/entry_register.sv
rtl/lockout_timer.sv
rtl/buzzer_tone.sv
rtl/lock_fsm.sv
rtl/keypad_lock_top.sv
verif/keypad_lock_asserts.sv
verif/keypad_lock_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the keypad lock testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module keypad_lock_tb -o keypad_lock_sim \
    && ./obj_dir/keypad_lock_sim +verilator+error+limit+100 | tee /dev/stderr \
        | grep -qx "No errors" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- verif/keypad_lock_tb.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock_tb;
    import lock_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 16;
    localparam int unsigned MAX_EXTRA    = 8;     // release lines get 1 up to this many more
    localparam string       STIM_FILE    = "verif/lock_stimulus.txt";

    // one line of the stimulus file
    typedef struct packed {
        logic [15:0] onehot;
        int          hold;
        logic [3:0]  flags;     // bit 0 random extra, 1 buzzer high on cycle 2, 2 buzzer low
        logic [11:0] display;
        logic [1:0]  count;
        logic [1:0]  tries;
    } step_t;

    logic          clk;
    logic          RSTn;
    logic [15:0]   onehot;
    display_word_u display;
    logic [1:0]    digit_count;
    logic [1:0]    tries;
    logic          buzzer;

    step_t steps[$];
    int    error_count = 0;
    int    check_count = 0;
    int    watchdog_cycles = 0;

    keypad_lock_top DUT (
        .clk         (clk),
        .RSTn        (RSTn),
        .onehot      (onehot),
        .display     (display),
        .digit_count (digit_count),
        .tries       (tries),
        .buzzer      (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic load_steps();
        int          fd;
        int          fields;
        string       line;
        logic [15:0] key;
        int          hold;
        logic [3:0]  flags;
        logic [11:0] disp;
        logic [1:0]  count;
        logic [1:0]  tr;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the stimulus file %s", STIM_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin   // hash lines are notes
                fields = $sscanf(line, "%h %d %h %h %d %d", key, hold, flags, disp, count, tr);
                if (fields == 6) begin
                    steps.push_back('{key, hold, flags, disp, count, tr});
                end else if (fields > 0) begin
                    error_count++;
                    $display("a stimulus line could not be read: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // drive on the falling edge, check once the hold is over
    task automatic run_step(input step_t step);
        int hold;
        hold = step.hold;
        if (step.flags[0]) begin
            hold += 1 + int'($urandom % MAX_EXTRA);
        end
        onehot = step.onehot;
        for (int n = 1; n <= hold; n++) begin
            @(negedge clk);
            if (step.flags[1] && n == 2) begin
                check_value(32'(buzzer), 32'd1, "buzzer two cycles after the key");
            end
        end
        check_value(32'(display), 32'(step.display), "display");
        check_value(32'(tries), 32'(step.tries), "tries");
        check_value(32'(digit_count), 32'(step.count), "digit_count");
        if (step.flags[2]) begin
            check_value(32'(buzzer), 32'd0, "buzzer at end of hold");
        end
    endtask

    initial begin
        int total_hold;
        RSTn   = 1'b0;
        onehot = '0;
        void'($urandom(32'h3bfa));
        load_steps();
        if (steps.size() == 0) begin
            error_count++;
            $display("no stimulus steps were read");
        end
        total_hold = 0;
        foreach (steps[i]) begin
            total_hold += steps[i].hold + (steps[i].flags[0] ? int'(MAX_EXTRA) : 0);
        end
        watchdog_cycles = RESET_CYCLES + total_hold + 25 * SECOND_TICKS + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        RSTn = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        error_count += DUT.u_lock_asserts.fail_count;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/keypad_lock_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock_asserts (
    input wire                          clk,
    input wire                          RSTn,
    input wire lock_pkg::lock_state_e   state,
    input wire [1:0]                    tries,
    input wire lock_pkg::display_word_u display,
    input wire                          active,
    input wire                          buzzer
);
    import lock_pkg::*;

    int tries_fails = 0;
    int display_fails = 0;
    int buzzer_fails = 0;
    int fail_count;

    assign fail_count = tries_fails + display_fails + buzzer_fails;

    // the third failed try goes straight to lockout
    tries_below_max: assert property (@(posedge clk) disable iff (!RSTn)
        tries < 2'(MAX_TRIES))
        else begin
            tries_fails++;
            $error("tries reached the lockout limit");
        end

    open_display_stable: assert property (@(posedge clk) disable iff (!RSTn)
        (state == ST_OPEN && $past(state) == ST_OPEN) |-> $stable(display))
        else begin
            display_fails++;
            $error("display changed while the lock was open");
        end

    quiet_when_idle: assert property (@(posedge clk) disable iff (!RSTn)
        !active |-> !buzzer)
        else begin
            buzzer_fails++;
            $error("buzzer high with no pattern playing");
        end

endmodule

bind keypad_lock_top keypad_lock_asserts u_lock_asserts (
    .clk     (clk),
    .RSTn    (RSTn),
    .state   (u_lock_fsm.state),
    .tries   (tries),
    .display (display),
    .active  (u_buzzer_tone.active),
    .buzzer  (buzzer)
);

`default_nettype wire

//--- rtl/keypad_lock_top.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock_top (
    input  wire                     clk,
    input  wire                     RSTn,
    input  wire [15:0]              onehot,
    output lock_pkg::display_word_u display,
    output logic [1:0]              digit_count,
    output logic [1:0]              tries,
    output logic                    buzzer
);
    import lock_pkg::*;
    import tone_pkg::*;

    key_event_t    key_event;
    display_word_u entry;
    display_word_u seconds;
    tone_req_t     tone_req;
    logic          shift_en;
    logic          clear_en;
    logic [3:0]    digit;
    logic          timer_start;
    logic          timer_done;

    key_decoder u_key_decoder (
        .clk       (clk),
        .RSTn      (RSTn),
        .onehot    (onehot),
        .key_event (key_event)
    );

    entry_register u_entry_register (
        .clk         (clk),
        .RSTn        (RSTn),
        .shift_en    (shift_en),
        .clear_en    (clear_en),
        .digit       (digit),
        .entry       (entry),
        .digit_count (digit_count)
    );

    lockout_timer u_lockout_timer (
        .clk     (clk),
        .RSTn    (RSTn),
        .start   (timer_start),
        .seconds (seconds),
        .done    (timer_done)
    );

    buzzer_tone u_buzzer_tone (
        .clk      (clk),
        .RSTn     (RSTn),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

    lock_fsm u_lock_fsm (
        .clk         (clk),
        .RSTn        (RSTn),
        .key_event   (key_event),
        .entry       (entry),
        .digit_count (digit_count),
        .seconds     (seconds),
        .timer_done  (timer_done),
        .shift_en    (shift_en),
        .clear_en    (clear_en),
        .digit       (digit),
        .timer_start (timer_start),
        .tone_req    (tone_req),
        .tries       (tries),
        .display     (display)
    );

endmodule

`default_nettype wire

//--- rtl/lock_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module lock_fsm (
    input  wire                          clk,
    input  wire                          RSTn,
    input  wire lock_pkg::key_event_t    key_event,
    input  wire lock_pkg::display_word_u entry,
    input  wire [1:0]                    digit_count,
    input  wire lock_pkg::display_word_u seconds,
    input  wire                          timer_done,
    output logic                         shift_en,
    output logic                         clear_en,
    output logic [3:0]                   digit,
    output logic                         timer_start,
    output tone_pkg::tone_req_t          tone_req,
    output logic [1:0]                   tries,
    output lock_pkg::display_word_u      display
);
    import lock_pkg::*;
    import tone_pkg::*;

    lock_state_e   state;
    display_word_u entry_next;
    logic          is_digit, is_enter, is_clear, is_reset_all;
    logic          code_full, enter_ok, enter_fail, last_try;

    assign is_digit     = key_event.valid && (key_event.cmd == KEY_DIGIT);
    assign is_enter     = key_event.valid && (key_event.cmd == KEY_ENTER);
    assign is_clear     = key_event.valid && (key_event.cmd == KEY_CLEAR);
    assign is_reset_all = key_event.valid && (key_event.cmd == KEY_RESET_ALL);

    assign code_full  = (digit_count == 2'd3);
    assign enter_ok   = (state == ST_ENTRY) && is_enter && code_full && (entry == SECRET_CODE);
    assign enter_fail = (state == ST_ENTRY) && is_enter && code_full && (entry != SECRET_CODE);
    assign last_try   = (tries == 2'(MAX_TRIES - 1));

    assign shift_en    = (state == ST_ENTRY) && is_digit && !code_full;
    assign clear_en    = ((state == ST_ENTRY) && (is_clear || is_reset_all || enter_fail)) ||
                         ((state == ST_OPEN) && (is_clear || is_reset_all));
    assign digit       = key_event.digit;
    assign timer_start = enter_fail && last_try;

    always_comb begin
        tone_req.start = 1'b1;
        tone_req.kind  = TONE_CLICK;
        if (enter_ok) begin
            tone_req.kind = TONE_SUCCESS;
        end else if (enter_fail) begin
            tone_req.kind = TONE_FAIL;
        end else if (!(is_digit && state != ST_LOCKOUT)) begin
            tone_req.start = 1'b0;
        end
    end

    // what the entry register holds after this edge, so the display keeps step
    always_comb begin
        entry_next = entry;
        if (clear_en) begin
            entry_next = {3{BLANK_NIBBLE}};
        end else if (shift_en) begin
            entry_next = {entry.entry_view.tens, entry.entry_view.units, key_event.digit};
        end
    end

    always_ff @(posedge clk) begin
        if (!RSTn) begin
            state   <= ST_ENTRY;
            tries   <= 2'd0;
            display <= {3{BLANK_NIBBLE}};
        end else begin
            case (state)
                ST_ENTRY: begin
                    display <= entry_next;
                    if (enter_ok) begin
                        state   <= ST_OPEN;
                        display <= PASS_GLYPH;
                    end else if (enter_fail && last_try) begin
                        state   <= ST_LOCKOUT;
                        tries   <= 2'd0;
                        display <= {BLANK_NIBBLE, 8'h00};   // timer view at 00
                    end else if (enter_fail) begin
                        tries <= tries + 2'd1;
                    end else if (is_reset_all) begin
                        tries <= 2'd0;
                    end
                end
                ST_OPEN: begin
                    display <= PASS_GLYPH;
                    if (is_clear || is_reset_all) begin
                        state   <= ST_ENTRY;
                        display <= {3{BLANK_NIBBLE}};
                    end
                    if (is_reset_all) begin
                        tries <= 2'd0;
                    end
                end
                ST_LOCKOUT: begin
                    display <= seconds;     // keys ignored here
                    if (timer_done) begin
                        state   <= ST_ENTRY;
                        display <= {3{BLANK_NIBBLE}};
                    end
                end
                default: state <= ST_ENTRY;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/buzzer_tone.sv
`timescale 1ns/1ns
`default_nettype none

module buzzer_tone (
    input  wire                 clk,
    input  wire                 RSTn,
    input  wire tone_pkg::tone_req_t tone_req,
    output logic                buzzer
);
    import tone_pkg::*;

    logic       active;         // a pattern is playing
    logic       phase;
    logic       phase_next;
    tone_kind_e kind;
    logic [6:0] len_cnt;
    logic [2:0] half_cnt;
    logic [6:0] len_lim;
    logic [2:0] half_lim;
    logic       half_end;
    logic       in_gap;

    always_comb begin
        case (kind)
            TONE_SUCCESS: begin
                len_lim  = 7'(SUCCESS_LEN);
                half_lim = 3'(SUCCESS_HALF);
            end
            TONE_FAIL: begin
                len_lim  = 7'(FAIL_LEN);
                half_lim = 3'(FAIL_HALF);
            end
            default: begin
                len_lim  = 7'(CLICK_LEN);
                half_lim = 3'(CLICK_HALF);
            end
        endcase
    end

    assign half_end   = (half_cnt == half_lim - 3'd1);
    assign phase_next = half_end ? ~phase : phase;
    assign in_gap     = (kind == TONE_FAIL) && (len_cnt >= 7'(FAIL_GAP_LO))
                        && (len_cnt < 7'(FAIL_GAP_HI));     // fail tone goes quiet here

    always_ff @(posedge clk) begin
        if (!RSTn) begin
            active   <= 1'b0;
            phase    <= 1'b0;
            buzzer   <= 1'b0;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else if (tone_req.start) begin   // restarts whatever is playing
            active   <= 1'b1;
            kind     <= tone_req.kind;
            phase    <= 1'b1;
            buzzer   <= 1'b1;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            len_cnt  <= len_cnt + 7'd1;
            half_cnt <= half_end ? 3'd0 : half_cnt + 3'd1;
            phase    <= phase_next;
            if (len_cnt == len_lim - 7'd1) begin
                active <= 1'b0;
                buzzer <= 1'b0;
            end else begin
                buzzer <= phase_next && !in_gap;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lockout_timer.sv
`timescale 1ns/1ns
`default_nettype none

module lockout_timer (
    input  wire                     clk,
    input  wire                     RSTn,
    input  wire                     start,
    output lock_pkg::display_word_u seconds,
    output logic                    done
);
    import lock_pkg::*;

    logic                            running;
    logic [$clog2(SECOND_TICKS)-1:0] tick_cnt;
    logic [3:0]                      sec_tens;
    logic [3:0]                      sec_units;

    always_ff @(posedge clk) begin
        if (!RSTn) begin
            running   <= 1'b0;
            done      <= 1'b0;
            tick_cnt  <= '0;
            sec_tens  <= 4'd0;
            sec_units <= 4'd0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running   <= 1'b1;
                tick_cnt  <= '0;
                sec_tens  <= 4'd0;
                sec_units <= 4'd0;
            end else if (running) begin
                if (tick_cnt == ($clog2(SECOND_TICKS))'(SECOND_TICKS - 1)) begin
                    tick_cnt <= '0;
                    if (sec_units == 4'd9) begin   // carry into tens
                        sec_units <= 4'd0;
                        sec_tens  <= sec_tens + 4'd1;
                        if (sec_tens + 4'd1 == LOCKOUT_SECONDS) begin
                            running <= 1'b0;
                            done    <= 1'b1;
                        end
                    end else begin
                        sec_units <= sec_units + 4'd1;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        seconds.timer_view.spare     = BLANK_NIBBLE;
        seconds.timer_view.sec_tens  = sec_tens;
        seconds.timer_view.sec_units = sec_units;
    end

endmodule

`default_nettype wire

//--- rtl/entry_register.sv
`timescale 1ns/1ns
`default_nettype none

module entry_register (
    input  wire                     clk,
    input  wire                     RSTn,
    input  wire                     shift_en,
    input  wire                     clear_en,
    input  wire [3:0]               digit,
    output lock_pkg::display_word_u entry,
    output logic [1:0]              digit_count
);
    import lock_pkg::*;

    // newest digit sits in units, older digits move up
    always_ff @(posedge clk) begin
        if (!RSTn) begin
            entry       <= {3{BLANK_NIBBLE}};
            digit_count <= 2'd0;
        end else if (clear_en) begin
            entry       <= {3{BLANK_NIBBLE}};
            digit_count <= 2'd0;
        end else if (shift_en) begin
            entry <= {entry.entry_view.tens, entry.entry_view.units, digit};
            if (digit_count != 2'd3) begin
                digit_count <= digit_count + 2'd1;   // saturates at three
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
    input  wire                 clk,
    input  wire                 RSTn,
    input  wire [15:0]          onehot,
    output lock_pkg::key_event_t key_event
);
    import lock_pkg::*;

    key_event_t cur_key;
    key_event_t prev_key;

    // mapping follows the keypad wiring
    always_comb begin
        cur_key.cmd   = KEY_DIGIT;
        cur_key.digit = BLANK_NIBBLE;
        case (onehot)
            16'h0008: cur_key.digit = 4'd0;
            16'h0080: cur_key.digit = 4'd1;
            16'h0040: cur_key.digit = 4'd2;
            16'h0020: cur_key.digit = 4'd3;
            16'h0800: cur_key.digit = 4'd4;
            16'h0400: cur_key.digit = 4'd5;
            16'h0200: cur_key.digit = 4'd6;
            16'h8000: cur_key.digit = 4'd7;
            16'h4000: cur_key.digit = 4'd8;
            16'h2000: cur_key.digit = 4'd9;
            16'h0001: cur_key.cmd   = KEY_ENTER;
            16'h1000: cur_key.cmd   = KEY_CLEAR;
            16'h0100: cur_key.cmd   = KEY_RESET_ALL;
            default:  cur_key.cmd   = KEY_NONE;   // no key or several keys
        endcase
        cur_key.valid = (cur_key.cmd != KEY_NONE);  // a real key is down
    end

    always_ff @(posedge clk) begin
        if (!RSTn) begin
            prev_key  <= '0;        // KEY_NONE
            key_event <= '0;
        end else begin
            prev_key <= cur_key;
            key_event.valid <= cur_key.valid && (cur_key != prev_key);
            key_event.cmd   <= cur_key.cmd;
            key_event.digit <= cur_key.digit;
        end
    end

endmodule

`default_nettype wire

//--- rtl/tone_pkg.sv
`default_nettype none

package tone_pkg;

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_kind_e;

    typedef struct packed {
        logic       start;      // one-cycle request
        tone_kind_e kind;
    } tone_req_t;

    // all values in clock cycles, scaled down for simulation
    localparam int CLICK_HALF = 2;
    localparam int CLICK_LEN = 20;
    localparam int SUCCESS_HALF = 1;
    localparam int SUCCESS_LEN = 60;
    localparam int FAIL_HALF = 4;
    localparam int FAIL_LEN = 90;
    localparam int FAIL_GAP_LO = 30;    // silent window inside the fail tone
    localparam int FAIL_GAP_HI = 60;

endpackage

`default_nettype wire

//--- rtl/lock_pkg.sv
`default_nettype none

package lock_pkg;

    // stored code 2 4 6, one BCD digit per nibble
    localparam logic [11:0] SECRET_CODE = 12'h246;
    localparam logic [3:0]  BLANK_NIBBLE = 4'hF;        // unlit digit position
    localparam logic [11:0] PASS_GLYPH = 12'hBCC;       // "ASS" on three digits

    localparam int MAX_TRIES = 3;                       // failed tries before lockout

    // lockout second length, scaled down for simulation
    localparam int SECOND_TICKS = 20;
    localparam logic [3:0] LOCKOUT_SECONDS = 4'd2;      // tens value that ends lockout

    typedef enum logic [2:0] {
        KEY_NONE,
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR,
        KEY_RESET_ALL
    } key_cmd_e;

    typedef struct packed {
        logic       valid;      // one-cycle strobe
        key_cmd_e   cmd;
        logic [3:0] digit;      // BCD, only meaningful for KEY_DIGIT
    } key_event_t;

    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] units;
    } entry_view_t;

    typedef struct packed {
        logic [3:0] spare;      // kept blank during lockout
        logic [3:0] sec_tens;
        logic [3:0] sec_units;
    } timer_view_t;

    // one display word, read as an entry or as the lockout seconds
    typedef union packed {
        entry_view_t entry_view;
        timer_view_t timer_view;
    } display_word_u;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKOUT
    } lock_state_e;

endpackage

`default_nettype wire
